// ==== Makefile ====
# Verilator build for the spu host bridge

VERILATOR  ?= verilator
TOP        := spu_host_tb
RTL_TOP    := spu_host_top
FILELIST   := spu_host.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// ==== spu_host.f ====
verilog/spu_host_pkg.sv
verilog/spu_sample_ram.sv
verilog/spu_control_regs.sv
verilog/spu_bus_bridge.sv
verilog/spu_host_top.sv
test/spu_host_tb.sv

// ==== test/spu_host_tb.sv ====
// directed testbench for the spu host bridge with a small spu register model
`timescale 1ns/1ps

module spu_host_tb import spu_host_pkg::*; ();

	localparam int clk_period  = 40;
	localparam int drive_delay = 2;     // inputs change after the edge
	localparam int ram_aw      = 12;    // small sample ram for the run
	localparam int cycle_limit = 2000;  // tests need under 200 cycles

	logic                  clk_sys;
	logic                  reset;
	bus_req_t              bus_req;
	bus_rsp_t              bus_rsp;
	spu_strobe_t           spu_strobe;
	logic [spu_data_w-1:0] spu_dout;
	spu_flags_t            spu_flags;
	logic                  spu_run_n_rst;
	ram_req_t              ram_req;
	logic [spu_data_w-1:0] ram_rdata;
	stereo_sample_t        audio_in;
	logic                  audio_valid;
	stereo_sample_t        audio_out;

	integer seed;
	int     cycle_count;
	int     wr_count;      // spu write strobes seen
	int     rd_count;      // spu read strobes seen
	int     rvalid_count;  // readdatavalid pulses seen

	logic [spu_data_w-1:0] spu_regs [0:(1<<spu_addr_w)-1];  // spu model registers
	logic [spu_addr_w-1:0] used_idx [0:7];                  // registers written
	logic [spu_data_w-1:0] used_val [0:7];

	spu_host_top #(
		.ram_addr_w (ram_aw)
	) dut_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.bus_req       (bus_req),
		.bus_rsp       (bus_rsp),
		.spu_strobe    (spu_strobe),
		.spu_dout      (spu_dout),
		.spu_flags     (spu_flags),
		.spu_run_n_rst (spu_run_n_rst),
		.ram_req       (ram_req),
		.ram_rdata     (ram_rdata),
		.audio_in      (audio_in),
		.audio_valid   (audio_valid),
		.audio_out     (audio_out)
	);

	initial clk_sys = 1'b0;
	always #(clk_period/2) clk_sys = ~clk_sys;

	// ============================================================
	// spu model and monitors
	// ============================================================
	assign spu_dout = spu_regs[spu_strobe.addr];  // register read port

	always @(posedge clk_sys) begin
		if (spu_strobe.cs && spu_strobe.wr) begin
			spu_regs[spu_strobe.addr] <= spu_strobe.din;
		end
	end

	always @(negedge clk_sys) begin
		if (spu_strobe.cs && spu_strobe.wr) wr_count++;
		if (spu_strobe.cs && spu_strobe.rd) rd_count++;
		if (bus_rsp.readdatavalid) rvalid_count++;
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			fail_run($sformatf("run timed out after %0d cycles", cycle_limit));
		end
	end

	// ============================================================
	// helpers
	// ============================================================
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic step();
		@(posedge clk_sys);
		#drive_delay;
	endtask

	// hold write until an edge with waitrequest low takes it
	task automatic bus_write(input logic [bus_addr_w-1:0] addr, input logic [bus_data_w-1:0] data);
		bus_req.address   = addr;
		bus_req.writedata = data;
		bus_req.write     = 1'b1;
		while (bus_rsp.waitrequest) step();  // busy, keep holding
		@(posedge clk_sys);
		#drive_delay;
		bus_req.write = 1'b0;
	endtask

	task automatic bus_read(input logic [bus_addr_w-1:0] addr, output logic [bus_data_w-1:0] data);
		int rv_before;
		rv_before       = rvalid_count;
		bus_req.address = addr;
		bus_req.read    = 1'b1;
		while (bus_rsp.waitrequest) step();  // busy, keep holding
		@(posedge clk_sys);
		#drive_delay;
		bus_req.read = 1'b0;
		while (!bus_rsp.readdatavalid) step();  // wait for the data pulse
		data = bus_rsp.readdata;
		step();
		check("readdatavalid after pulse", 32'(bus_rsp.readdatavalid), 32'd0);
		check("readdatavalid pulse count", 32'(rvalid_count - rv_before), 32'd1);
	endtask

	// ============================================================
	// tests
	// ============================================================
	task automatic test_reset();
		step();
		check("waitrequest", 32'(bus_rsp.waitrequest), 32'd0);
		check("readdatavalid", 32'(bus_rsp.readdatavalid), 32'd0);
		check("readdata", bus_rsp.readdata, 32'd0);
		check("spu_strobe.cs", 32'(spu_strobe.cs), 32'd0);
		check("spu_strobe.rd", 32'(spu_strobe.rd), 32'd0);
		check("spu_strobe.wr", 32'(spu_strobe.wr), 32'd0);
		check("spu_run_n_rst", 32'(spu_run_n_rst), 32'd1);  // running out of reset
		check("audio_out", audio_out, 32'd0);
	endtask

	task automatic test_reg_write();
		logic [31:0]           rnd;
		logic [31:0]           data;
		logic [bus_addr_w-1:0] byte_addr;
		int                    wr_before;
		for (int i = 0; i < 8; i++) begin
			rnd         = $random(seed);
			data        = $random(seed);
			used_idx[i] = {rnd[6:0], 3'(i)};  // distinct register per pass
			used_val[i] = data[15:0];
			byte_addr   = {8'h00, used_idx[i], 2'b00};
			wr_before   = wr_count;
			bus_write(byte_addr, data);
			step();  // strobe cycle
			check("spu_strobe.cs", 32'(spu_strobe.cs), 32'd1);
			check("spu_strobe.wr", 32'(spu_strobe.wr), 32'd1);
			check("spu_strobe.rd", 32'(spu_strobe.rd), 32'd0);
			check("spu_strobe.addr", 32'(spu_strobe.addr), 32'(byte_addr >> 2));
			check("spu_strobe.din", 32'(spu_strobe.din), 32'(data[15:0]));
			check("waitrequest", 32'(bus_rsp.waitrequest), 32'd1);
			while (bus_rsp.waitrequest) step();
			check("write strobe count", 32'(wr_count - wr_before), 32'd1);
		end
	endtask

	task automatic test_reg_read();
		logic [31:0] data;
		int          rd_before;
		for (int i = 7; i >= 0; i--) begin
			rd_before = rd_count;
			bus_read({8'h00, used_idx[i], 2'b00}, data);
			check("readdata", data, {used_val[i], used_val[i]});  // value in both halves
			check("read strobe count", 32'(rd_count - rd_before), 32'd1);
		end
	endtask

	task automatic test_control();
		localparam logic [bus_addr_w-1:0] ctrl_addr = 20'h02010;  // bit 13 set
		logic [31:0] data;
		logic [31:0] exp;
		logic [2:0]  kb;
		int          wr_before;
		int          rd_before;
		wr_before = wr_count;
		rd_before = rd_count;
		bus_write(ctrl_addr, 32'h0000_0000);
		step();
		check("spu_run_n_rst", 32'(spu_run_n_rst), 32'd0);  // spu held in reset
		for (int k = 0; k < 8; k++) begin
			kb                  = 3'(k);
			spu_flags.spu_int   = kb[0];
			spu_flags.spu_dreq  = kb[1];
			spu_flags.fifo_full = kb[2];
			exp     = 32'h0;
			exp[30] = kb[2];
			exp[29] = kb[0];
			exp[28] = kb[1];
			bus_read(ctrl_addr, data);
			check("flag word", data, exp);
		end
		bus_write(ctrl_addr, 32'h0000_0001);
		step();
		check("spu_run_n_rst", 32'(spu_run_n_rst), 32'd1);
		spu_flags = '0;
		bus_read(ctrl_addr, data);
		check("flag word", data, 32'h0000_0001);  // run bit alone
		check("control write strobes", 32'(wr_count - wr_before), 32'd0);
		check("control read strobes", 32'(rd_count - rd_before), 32'd0);
	endtask

	task automatic test_audio();
		logic [31:0]    rnd;
		stereo_sample_t exp_out;
		exp_out = '0;
		for (int i = 0; i < 24; i++) begin
			rnd         = $random(seed);
			audio_in    = rnd;
			rnd         = $random(seed);
			audio_valid = rnd[3];
			step();
			if (audio_valid) exp_out = audio_in;  // hold updates only when valid
			check("audio_out", audio_out, exp_out);
		end
		audio_valid = 1'b0;
	endtask

	task automatic test_ram();
		logic [31:0]           rnd;
		logic [ram_aw-1:0]     addrs [0:15];
		logic [spu_data_w-1:0] vals  [0:15];
		for (int i = 0; i < 16; i++) begin
			rnd           = $random(seed);
			addrs[i]      = {rnd[ram_aw-5:0], 4'(i)};  // low bits keep addresses apart
			vals[i]       = rnd[31:16];
			ram_req.addr  = 18'(addrs[i]);
			ram_req.wdata = vals[i];
			ram_req.wr    = 1'b1;
			step();
		end
		ram_req.wr = 1'b0;
		for (int i = 15; i >= 0; i--) begin
			ram_req.addr = 18'(addrs[i]);
			ram_req.rd   = 1'b1;
			step();  // read captured here
			ram_req.rd = 1'b0;
			check("ram_rdata", 32'(ram_rdata), 32'(vals[i]));
			step();
			check("ram_rdata held", 32'(ram_rdata), 32'(vals[i]));
		end
	endtask

	// ============================================================
	// main sequence
	// ============================================================
	initial begin
		seed        = 32'h48d7_2fce;
		reset       = 1'b1;
		bus_req     = '0;
		spu_flags   = '0;
		ram_req     = '0;
		audio_in    = '0;
		audio_valid = 1'b0;
		repeat (2) @(posedge clk_sys);
		#drive_delay;
		check("waitrequest in reset", 32'(bus_rsp.waitrequest), 32'd1);
		reset = 1'b0;
		test_reset();
		test_reg_write();
		test_reg_read();
		test_control();
		test_audio();
		test_ram();
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== verilog/spu_bus_bridge.sv ====
// memory-mapped host slave that turns reads and writes into spu register strobes
`timescale 1ns/1ps

module spu_bus_bridge import spu_host_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  bus_req_t    bus_req,     // host request
	output bus_rsp_t    bus_rsp,     // host response
	output spu_strobe_t spu_strobe,  // to the external spu
	input  logic [spu_data_w-1:0] spu_dout,
	input  spu_flags_t  spu_flags,
	input  logic        spu_run,     // current run bit from control regs
	output logic        run_we,      // one cycle write of the run bit
	output logic        run_val
);

	bridge_state_e         state;
	logic                  phase;       // 0 first busy cycle, 1 second
	logic                  ctrl_sel;    // current read targets the flag word
	logic                  wait_q;
	logic                  rvalid_q;
	logic [bus_data_w-1:0] rdata_q;
	spu_strobe_t           strobe_q;
	logic                  run_we_q;
	logic                  run_val_q;

	logic                  ctrl_hit;    // request falls in control window
	logic [spu_addr_w-1:0] spu_reg_addr;
	logic [bus_data_w-1:0] flag_word;

	// ============================================================
	// request decode and flag word
	// ============================================================
	assign ctrl_hit     = bus_req.address[ctrl_window_bit];
	assign spu_reg_addr = bus_req.address[spu_addr_w+1:2];  // byte to word index

	always_comb begin
		flag_word = '0;
		flag_word[flag_fifo_full_bit] = spu_flags.fifo_full;
		flag_word[flag_int_bit]       = spu_flags.spu_int;
		flag_word[flag_dreq_bit]      = spu_flags.spu_dreq;
		flag_word[flag_run_bit]       = spu_run;
	end

	// ============================================================
	// bus state machine
	// ============================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state     <= bus_idle;
			phase     <= 1'b0;
			ctrl_sel  <= 1'b0;
			wait_q    <= 1'b1;   // busy until reset is gone
			rvalid_q  <= 1'b0;
			rdata_q   <= '0;
			strobe_q  <= '0;
			run_we_q  <= 1'b0;
			run_val_q <= 1'b0;
		end else begin
			run_we_q <= 1'b0;  // single cycle pulse
			case (state)
				bus_idle: begin
					wait_q      <= 1'b0;
					rvalid_q    <= 1'b0;
					phase       <= 1'b0;
					strobe_q.cs <= 1'b0;
					strobe_q.rd <= 1'b0;
					strobe_q.wr <= 1'b0;
					if (bus_req.write) begin
						if (ctrl_hit) begin
							run_we_q  <= 1'b1;                // run bit, no strobe, no wait
							run_val_q <= bus_req.writedata[0];
						end else begin
							strobe_q.addr <= spu_reg_addr;
							strobe_q.din  <= bus_req.writedata[spu_data_w-1:0];
							wait_q        <= 1'b1;
							state         <= bus_write;
						end
					end else if (bus_req.read) begin
						ctrl_sel      <= ctrl_hit;
						strobe_q.addr <= spu_reg_addr;
						wait_q        <= !ctrl_hit;  // flag reads never stall
						state         <= bus_read;
					end
				end

				bus_write: begin
					if (!phase) begin
						phase       <= 1'b1;
						strobe_q.cs <= 1'b1;  // write strobe for one cycle
						strobe_q.wr <= 1'b1;
					end else begin
						phase       <= 1'b0;
						strobe_q.cs <= 1'b0;
						strobe_q.wr <= 1'b0;
						wait_q      <= 1'b0;  // drop before going idle
						state       <= bus_idle;
					end
				end

				bus_read: begin
					if (!phase) begin
						phase <= 1'b1;
						if (!ctrl_sel) begin
							strobe_q.cs <= 1'b1;  // read strobe for one cycle
							strobe_q.rd <= 1'b1;
						end
					end else begin
						phase       <= 1'b0;
						strobe_q.cs <= 1'b0;
						strobe_q.rd <= 1'b0;
						wait_q      <= 1'b0;
						rvalid_q    <= 1'b1;  // one valid pulse per read
						rdata_q     <= ctrl_sel ? flag_word : {spu_dout, spu_dout};
						state       <= bus_idle;
					end
				end

				default: state <= bus_idle;
			endcase
		end
	end

	// ============================================================
	// outputs
	// ============================================================
	assign bus_rsp.waitrequest   = wait_q;
	assign bus_rsp.readdatavalid = rvalid_q;
	assign bus_rsp.readdata      = rdata_q;
	assign spu_strobe            = strobe_q;
	assign run_we                = run_we_q;
	assign run_val               = run_val_q;

endmodule

// ==== verilog/spu_control_regs.sv ====
// spu run bit register and hold of the last valid stereo sample pair
`timescale 1ns/1ps

module spu_control_regs import spu_host_pkg::*; (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           run_we,      // write strobe from the bridge
	input  logic           run_val,     // new run bit value
	output logic           spu_run,     // 1 lets the spu run
	input  stereo_sample_t audio_in,    // sample pair from the spu
	input  logic           audio_valid, // audio_in is a new pair
	output stereo_sample_t audio_out
);

	logic           run_q;
	stereo_sample_t audio_q;

	// ============================================================
	// run bit
	// ============================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			run_q <= 1'b1;  // spu starts out running
		end else if (run_we) begin
			run_q <= run_val;
		end
	end

	// ============================================================
	// audio hold
	// ============================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio_q <= '0;
		end else if (audio_valid) begin
			audio_q <= audio_in;  // keep last valid pair otherwise
		end
	end

	assign spu_run   = run_q;
	assign audio_out = audio_q;

endmodule

// ==== verilog/spu_host_pkg.sv ====
// spu host bridge shared widths, flag word layout, bridge states and bus structs
package spu_host_pkg;

	// ============================================================
	// widths
	// ============================================================
	localparam int bus_addr_w      = 20;  // host byte address
	localparam int bus_data_w      = 32;  // host data path
	localparam int spu_addr_w      = 10;  // spu register index
	localparam int spu_data_w      = 16;  // spu register and sample data
	localparam int ctrl_window_bit = 13;  // high selects the control window
	localparam int ram_addr_max_w  = 18;  // widest sample ram word address

	// flag word bit positions
	localparam int flag_fifo_full_bit = 30;
	localparam int flag_int_bit       = 29;
	localparam int flag_dreq_bit      = 28;
	localparam int flag_run_bit       = 0;   // spu running, not held in reset

	// ============================================================
	// types
	// ============================================================
	typedef enum logic [1:0] {
		bus_idle,   // waiting for a host request
		bus_write,  // spu register write strobe
		bus_read    // spu register or flag read
	} bridge_state_e;

	typedef struct packed {
		logic [bus_addr_w-1:0] address;    // byte address
		logic [bus_data_w-1:0] writedata;
		logic                  read;       // held until accepted
		logic                  write;      // held until accepted
	} bus_req_t;

	typedef struct packed {
		logic                  waitrequest;
		logic                  readdatavalid;  // one pulse per read
		logic [bus_data_w-1:0] readdata;
	} bus_rsp_t;

	typedef struct packed {
		logic                  cs;
		logic                  rd;
		logic                  wr;
		logic [spu_addr_w-1:0] addr;   // register index, byte addr / 4
		logic [spu_data_w-1:0] din;
	} spu_strobe_t;

	typedef struct packed {
		logic spu_int;    // spu interrupt request
		logic spu_dreq;   // spu dma request
		logic fifo_full;  // spu transfer fifo full
	} spu_flags_t;

	typedef struct packed {
		logic [spu_data_w-1:0] left;
		logic [spu_data_w-1:0] right;
	} stereo_sample_t;

	typedef struct packed {
		logic [ram_addr_max_w-1:0] addr;   // word address, upper bits unused when narrower
		logic                      rd;
		logic                      wr;
		logic [spu_data_w-1:0]     wdata;
	} ram_req_t;

endpackage

// ==== verilog/spu_host_top.sv ====
// spu host bridge top level joining bus bridge, control registers and sample ram
`timescale 1ns/1ps

module spu_host_top import spu_host_pkg::*; #(
	parameter int ram_addr_w = 18  // sample ram word address width
) (
	input  logic                  clk_sys,
	input  logic                  reset,

	// host bus
	input  bus_req_t              bus_req,
	output bus_rsp_t              bus_rsp,

	// spu register port
	output spu_strobe_t           spu_strobe,
	input  logic [spu_data_w-1:0] spu_dout,
	input  spu_flags_t            spu_flags,
	output logic                  spu_run_n_rst,  // active low spu reset

	// spu memory port
	input  ram_req_t              ram_req,
	output logic [spu_data_w-1:0] ram_rdata,

	// audio
	input  stereo_sample_t        audio_in,
	input  logic                  audio_valid,
	output stereo_sample_t        audio_out
);

	logic run_we;   // control window write
	logic run_val;  // written run bit
	logic spu_run;  // held run bit

	// ============================================================
	// host side bridge
	// ============================================================
	spu_bus_bridge bridge_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus_req    (bus_req),
		.bus_rsp    (bus_rsp),
		.spu_strobe (spu_strobe),
		.spu_dout   (spu_dout),
		.spu_flags  (spu_flags),
		.spu_run    (spu_run),
		.run_we     (run_we),
		.run_val    (run_val)
	);

	// ============================================================
	// run bit and audio hold
	// ============================================================
	spu_control_regs ctrl_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.run_we      (run_we),
		.run_val     (run_val),
		.spu_run     (spu_run),
		.audio_in    (audio_in),
		.audio_valid (audio_valid),
		.audio_out   (audio_out)
	);

	assign spu_run_n_rst = spu_run;  // run bit high keeps spu out of reset

	// ============================================================
	// sample memory
	// ============================================================
	spu_sample_ram #(
		.ram_addr_w (ram_addr_w)
	) ram_i (
		.clk_sys   (clk_sys),
		.ram_req   (ram_req),
		.ram_rdata (ram_rdata)
	);

endmodule

// ==== verilog/spu_sample_ram.sv ====
// single-port synchronous 16-bit sample memory serving the spu memory port
`timescale 1ns/1ps

module spu_sample_ram import spu_host_pkg::*; #(
	parameter int ram_addr_w = 18  // word address width, at most ram_addr_max_w
) (
	input  logic                  clk_sys,
	input  ram_req_t              ram_req,    // spu memory request
	output logic [spu_data_w-1:0] ram_rdata   // valid one cycle after rd
);

	localparam int ram_depth = 2 ** ram_addr_w;

	logic [spu_data_w-1:0] mem [0:ram_depth-1];
	logic [ram_addr_w-1:0] word_addr;
	logic [spu_data_w-1:0] rdata_q;

	assign word_addr = ram_req.addr[ram_addr_w-1:0];  // drop unused upper bits

	// write port, stored on the edge
	always_ff @(posedge clk_sys) begin
		if (ram_req.wr) begin
			mem[word_addr] <= ram_req.wdata;
		end
	end

	// registered read, holds until next rd
	always_ff @(posedge clk_sys) begin
		if (ram_req.rd) begin
			rdata_q <= mem[word_addr];
		end
	end

	assign ram_rdata = rdata_q;

endmodule
